// ==== sampler.f ====
design/sampler_pkg.sv
design/sampler_fsm.sv
design/coeff_counter.sv
design/block_piso.sv
design/rej_filter.sv
design/sampler_top.sv
sim/sampler_checker.sv
sim/tb_sampler.sv

// ==== Makefile ====
# Verilator flow for the coefficient sampler
VERILATOR ?= verilator
TOP       ?= tb_sampler
FILELIST  ?= sampler.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/sampler_stim.txt ====
// columns: mode (0 uniform, 1 bounded), base address, max block delay, zeroize beat (0 none)
// all fields hex
0 0000 00 00
1 0100 00 00
0 0000 03 00
1 7fe0 05 00
0 0000 14 00
1 0040 14 00
0 0000 02 14
0 0000 01 00
1 0200 03 0a
1 0300 00 00
0 0000 0a 00
1 1234 0a 00

// ==== sim/tb_sampler.sv ====
/*
  sampler testbench
  runs the tests of the stim file against a hash model, checking through sampler_checker
*/
`timescale 1ns/1ps

module tb_sampler;

  localparam int unsigned MAX_TESTS       = 32;
  localparam int unsigned CYCLES_PER_TEST = 2000;
  localparam int unsigned SEED            = 46111;

  logic                                 clk;
  logic                                 rst_b;
  logic                                 zeroize;
  logic                                 start;
  sampler_pkg::sampler_mode_e           mode;
  logic [sampler_pkg::MEM_ADDR_W-1:0]   base_addr;
  logic                                 block_valid = 1'b0;
  logic [sampler_pkg::BLOCK_W-1:0]      block_data = '0;
  logic                                 hash_process;
  logic                                 hash_run;
  logic                                 block_hold;
  logic                                 busy;
  logic                                 ntt_dv;
  logic                                 mem_dv;
  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] ntt_data;
  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] mem_data;
  logic [sampler_pkg::MEM_ADDR_W-1:0]   mem_addr;
  logic [31:0]                          stim [4*MAX_TESTS];
  int unsigned                          test_cnt;
  int unsigned                          cycle_limit;
  int unsigned                          cycle_cnt;
  int unsigned                          max_delay;
  int                                   delay_left = -1;
  int                                   mismatch_cnt;
  int                                   other_cnt;

  sampler_top dut (
    .clk, .rst_b,
    .zeroize_i (zeroize), .start_i (start), .mode_i (mode),
    .dest_base_addr_i (base_addr),
    .block_valid_i (block_valid), .block_data_i (block_data),
    .process_o (hash_process), .run_o (hash_run), .block_hold_o (block_hold),
    .busy_o (busy), .ntt_dv_o (ntt_dv), .ntt_data_o (ntt_data),
    .mem_dv_o (mem_dv), .mem_data_o (mem_data), .mem_addr_o (mem_addr)
  );

  sampler_checker u_checker (
    .clk, .rst_b,
    .zeroize_i (zeroize), .start_i (start), .mode_i (mode), .base_addr_i (base_addr),
    .block_valid_i (block_valid), .block_data_i (block_data),
    .process_i (hash_process), .run_i (hash_run), .block_hold_i (block_hold),
    .busy_i (busy), .ntt_dv_i (ntt_dv), .ntt_data_i (ntt_data),
    .mem_dv_i (mem_dv), .mem_data_i (mem_data), .mem_addr_i (mem_addr),
    .mismatch_cnt_o (mismatch_cnt), .other_cnt_o (other_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [sampler_pkg::BLOCK_W-1:0] random_block();
    logic [sampler_pkg::BLOCK_W-1:0] blk;
    for (int i = 0; i < sampler_pkg::BLOCK_W / 32; i++) begin
      blk[32*i +: 32] = $urandom();
    end
    return blk;
  endfunction

  // hash model: one block per process or run pulse, held until it transfers
  always @(posedge clk) begin
    if (!rst_b || zeroize || !busy) begin
      delay_left = -1;
      block_valid <= 1'b0;
    end else begin
      if (block_valid && !block_hold) begin
        block_valid <= 1'b0;
      end
      if (hash_process || hash_run) begin
        delay_left = $urandom_range(max_delay, 0);
      end
      if (delay_left == 0) begin
        block_valid <= 1'b1;
        block_data  <= random_block();
        delay_left = -1;
      end else if (delay_left > 0) begin
        delay_left--;
      end
    end
  end

  task automatic run_test(input sampler_pkg::sampler_mode_e test_mode,
                          input logic [sampler_pkg::MEM_ADDR_W-1:0] test_base,
                          input int unsigned delay_bound,
                          input int unsigned zero_beat);
    int unsigned beats;
    logic        finished;
    logic        zeroized;
    beats    = 0;
    finished = 1'b0;
    zeroized = 1'b0;
    @(posedge clk);
    mode      <= test_mode;
    base_addr <= test_base;
    max_delay = delay_bound;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!finished) begin
      @(posedge clk);
      zeroize <= 1'b0;
      if (ntt_dv || mem_dv) begin
        beats++;
      end
      if (!busy) begin
        finished = 1'b1;
      end else if (zero_beat != 0 && beats == zero_beat && !zeroized) begin
        zeroize <= 1'b1;
        zeroized = 1'b1;
      end
    end
    repeat (3) @(posedge clk);
  endtask

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < 4 * MAX_TESTS; i++) begin
      stim[i] = '1;
    end
    $readmemh("sim/sampler_stim.txt", stim);
    test_cnt = 0;
    while (test_cnt < MAX_TESTS && stim[4*test_cnt] != '1) begin
      test_cnt++;
    end
    cycle_limit = test_cnt * CYCLES_PER_TEST;
    rst_b     = 1'b0;
    zeroize   = 1'b0;
    start     = 1'b0;
    mode      = sampler_pkg::MODE_REJ_SAMPLE;
    base_addr = '0;
    max_delay = 0;
    repeat (10) @(posedge clk);
    rst_b <= 1'b1;
    repeat (2) @(posedge clk);
    for (int unsigned t = 0; t < test_cnt; t++) begin
      run_test(sampler_pkg::sampler_mode_e'(stim[4*t][0]),
               stim[4*t+1][sampler_pkg::MEM_ADDR_W-1:0], stim[4*t+2], stim[4*t+3]);
    end
    if (test_cnt == 0) begin
      $display("no tests read from the stim file");
    end
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (test_cnt != 0 && mismatch_cnt == 0 && other_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests not finished after %0d cycles", cycle_cnt);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sim/sampler_checker.sv ====
/*
  sampler checker
  rebuilds the expected coefficient stream from transferred blocks and checks the DUT ports
*/
`timescale 1ns/1ps

module sampler_checker (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 zeroize_i,
  input  logic                                 start_i,
  input  sampler_pkg::sampler_mode_e           mode_i,
  input  logic [sampler_pkg::MEM_ADDR_W-1:0]   base_addr_i,
  input  logic                                 block_valid_i,
  input  logic [sampler_pkg::BLOCK_W-1:0]      block_data_i,
  input  logic                                 process_i,
  input  logic                                 run_i,
  input  logic                                 block_hold_i,
  input  logic                                 busy_i,
  input  logic                                 ntt_dv_i,
  input  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] ntt_data_i,
  input  logic                                 mem_dv_i,
  input  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] mem_data_i,
  input  logic [sampler_pkg::MEM_ADDR_W-1:0]   mem_addr_i,
  output int                                   mismatch_cnt_o,
  output int                                   other_cnt_o
);

  logic [sampler_pkg::COEFF_W-1:0]    exp_q [$];
  sampler_pkg::sampler_mode_e         run_mode = sampler_pkg::MODE_REJ_SAMPLE;
  logic [sampler_pkg::MEM_ADDR_W-1:0] exp_addr = '0;
  int unsigned                        beats = 0;
  int unsigned                        cyc = 0;
  int unsigned                        last_beat_cyc = 0;
  int                                 mismatches = 0;
  int                                 faults = 0;
  logic                               aborted = 1'b1;
  logic                               xfer;
  logic                               prev_start = 1'b0;
  logic                               prev_zero = 1'b0;
  logic                               prev_xfer = 1'b0;
  logic                               prev_busy = 1'b0;

  assign mismatch_cnt_o = mismatches;
  assign other_cnt_o    = faults;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatches++;
    $display("Mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_fault(input string msg);
    faults++;
    $display("%s at %0t", msg, $time);
  endtask

  // accepted candidates of one block, lowest field first
  task automatic push_block(input logic [sampler_pkg::BLOCK_W-1:0] blk);
    int unsigned v;
    if (run_mode == sampler_pkg::MODE_REJ_BOUNDED) begin
      for (int i = 0; i < sampler_pkg::BLOCK_W / 4; i++) begin
        v = 32'(blk[4*i +: 4]);
        // eta - (v mod 5), folded into [0, q)
        if (v < sampler_pkg::REJB_BOUND) begin
          exp_q.push_back(24'((sampler_pkg::ETA + sampler_pkg::MLDSA_Q - v % 5)
                              % sampler_pkg::MLDSA_Q));
        end
      end
    end else begin
      for (int i = 0; i < sampler_pkg::BLOCK_W / 24; i++) begin
        v = 32'(blk[24*i +: 23]);
        if (v < sampler_pkg::MLDSA_Q) begin
          exp_q.push_back(24'(v));
        end
      end
    end
  endtask

  task automatic check_beat(input string name,
                            input logic [3:0][sampler_pkg::COEFF_W-1:0] data);
    logic [sampler_pkg::COEFF_W-1:0] exp;
    for (int k = 0; k < 4; k++) begin
      if (exp_q.size() == 0) begin
        report_fault($sformatf("%s[%0d] arrived with no expected coefficient left", name, k));
      end else begin
        exp = exp_q.pop_front();
        if (data[k] !== exp) begin
          report_mismatch($sformatf("%s[%0d]", name, k), 32'(data[k]), 32'(exp));
        end
      end
    end
  endtask

  always @(negedge clk) begin
    xfer = block_valid_i && !block_hold_i;
    if (!rst_b) begin
      aborted    = 1'b1;
      prev_start = 1'b0;
      prev_zero  = 1'b0;
      prev_xfer  = 1'b0;
      prev_busy  = 1'b0;
    end else begin
      cyc++;
      if (process_i !== (prev_start && !prev_zero)) begin
        report_mismatch("process_o", 32'(process_i), 32'(prev_start && !prev_zero));
      end
      if (run_i !== (prev_xfer && !prev_zero && beats < sampler_pkg::BEAT_CNT)) begin
        report_mismatch("run_o", 32'(run_i),
                        32'(prev_xfer && !prev_zero && beats < sampler_pkg::BEAT_CNT));
      end
      if (prev_xfer && !block_hold_i) begin
        report_fault("block_hold_o low in the cycle after a block transfer");
      end
      if (start_i && !busy_i) begin
        report_fault("busy_o low while start_i is high");
      end
      if (prev_zero && busy_i && !start_i) begin
        report_fault("busy_o still high in the cycle after zeroize");
      end
      if (ntt_dv_i && mem_dv_i) begin
        report_fault("ntt_dv_o and mem_dv_o high together");
      end
      if ((ntt_dv_i || mem_dv_i) && !busy_i) begin
        report_fault("output beat while busy_o is low");
      end
      if (start_i) begin
        exp_q.delete();
        beats    = 0;
        run_mode = mode_i;
        exp_addr = base_addr_i;
        aborted  = 1'b0;
      end
      if (ntt_dv_i || mem_dv_i) begin
        if (beats >= sampler_pkg::BEAT_CNT) begin
          report_fault("output beat after the last coefficient of the run");
        end
        if (mem_dv_i != (run_mode == sampler_pkg::MODE_REJ_BOUNDED)) begin
          report_fault("output beat on the port of the other mode");
        end
        if (mem_dv_i) begin
          if (mem_addr_i !== exp_addr) begin
            report_mismatch("mem_addr_o", 32'(mem_addr_i), 32'(exp_addr));
          end
          check_beat("mem_data_o", mem_data_i);
        end else begin
          check_beat("ntt_data_o", ntt_data_i);
        end
        exp_addr++;
        beats++;
        last_beat_cyc = cyc;
      end
      if (xfer) begin
        push_block(block_data_i);
      end
      // busy drops two cycles after the edge that closes the last beat
      if (prev_busy && !busy_i && !aborted) begin
        if (beats != sampler_pkg::BEAT_CNT) begin
          report_fault($sformatf("run ended after %0d beats instead of 64", beats));
        end else if (cyc - last_beat_cyc != 3) begin
          report_fault($sformatf("busy_o fell %0d cycles after the last beat instead of 2",
                                 cyc - last_beat_cyc - 1));
        end
      end
      if (zeroize_i) begin
        aborted = 1'b1;
      end
      prev_start = start_i;
      prev_zero  = zeroize_i;
      prev_xfer  = xfer;
      prev_busy  = busy_i;
    end
  end

endmodule

// ==== design/sampler_top.sv ====
/*
  coefficient sampler top
  sequences the hash, unpacks squeeze blocks and steers beats to the NTT or memory port
*/
`timescale 1ns/1ps

module sampler_top (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 zeroize_i,
  input  logic                                 start_i,
  input  sampler_pkg::sampler_mode_e           mode_i,
  input  logic [sampler_pkg::MEM_ADDR_W-1:0]   dest_base_addr_i,
  input  logic                                 block_valid_i,
  input  logic [sampler_pkg::BLOCK_W-1:0]      block_data_i,
  output logic                                 process_o,
  output logic                                 run_o,
  output logic                                 block_hold_o,
  output logic                                 busy_o,
  output logic                                 ntt_dv_o,
  output logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] ntt_data_o,
  output logic                                 mem_dv_o,
  output logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] mem_data_o,
  output logic [sampler_pkg::MEM_ADDR_W-1:0]   mem_addr_o
);

  logic                                 block_xfer;
  logic                                 done;
  logic                                 clear;
  logic                                 slice_valid;
  logic                                 slice_hold;
  logic [sampler_pkg::REJS_SLICE_W-1:0] slice_data;
  logic                                 beat;
  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] coeff;
  logic [sampler_pkg::MEM_ADDR_W-1:0]   dest_addr;

  assign block_xfer = block_valid_i & ~block_hold_o;
  // leftover slices and partial beats are dropped at the end of a run
  assign clear      = zeroize_i | done;

  sampler_fsm u_fsm (
    .clk, .rst_b, .zeroize_i, .start_i,
    .block_xfer_i (block_xfer),
    .done_i       (done),
    .process_o, .run_o, .busy_o
  );

  coeff_counter u_counter (
    .clk, .rst_b, .zeroize_i, .start_i,
    .beat_i (beat),
    .dest_base_addr_i,
    .done_o (done),
    .addr_o (dest_addr)
  );

  block_piso u_piso (
    .clk, .rst_b,
    .clear_i (clear),
    .mode_i, .block_valid_i, .block_data_i,
    .slice_hold_i  (slice_hold),
    .block_hold_o,
    .slice_valid_o (slice_valid),
    .slice_data_o  (slice_data)
  );

  rej_filter u_filter (
    .clk, .rst_b,
    .clear_i       (clear),
    .mode_i,
    .slice_valid_i (slice_valid),
    .slice_data_i  (slice_data),
    .slice_hold_o  (slice_hold),
    .beat_o        (beat),
    .coeff_o       (coeff)
  );

  // uniform samples feed the NTT, bounded ones go to memory
  always_comb begin
    ntt_dv_o   = 1'b0;
    ntt_data_o = '0;
    mem_dv_o   = 1'b0;
    mem_data_o = '0;
    mem_addr_o = '0;
    if (mode_i == sampler_pkg::MODE_REJ_BOUNDED) begin
      mem_dv_o   = beat;
      mem_data_o = coeff;
      mem_addr_o = dest_addr;
    end else begin
      ntt_dv_o   = beat;
      ntt_data_o = coeff;
    end
  end

  a_mode_stable: assert property (@(posedge clk) disable iff (!rst_b)
    busy_o && $past(busy_o) |-> $stable(mode_i));

endmodule

// ==== design/rej_filter.sv ====
/*
  rejection filter
  tests candidates by mode and packs the accepted ones into four-coefficient beats
*/
`timescale 1ns/1ps

module rej_filter (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 clear_i,
  input  sampler_pkg::sampler_mode_e           mode_i,
  input  logic                                 slice_valid_i,
  input  logic [sampler_pkg::REJS_SLICE_W-1:0] slice_data_i,
  output logic                                 slice_hold_o,
  output logic                                 beat_o,
  output logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W-1:0] coeff_o
);

  logic [sampler_pkg::COEFF_W-1:0]      store_q [sampler_pkg::FILTER_DEPTH];
  logic [sampler_pkg::FILTER_CNT_W-1:0] store_cnt;
  logic [sampler_pkg::COEFF_W-1:0]      cand_val [sampler_pkg::REJB_NUM_CAND];
  logic [sampler_pkg::REJB_NUM_CAND-1:0] cand_ok;
  logic [sampler_pkg::COEFF_W-1:0]      merged [sampler_pkg::FILTER_DEPTH];
  logic [sampler_pkg::FILTER_CNT_W:0]   merged_cnt;
  logic                                 take;

  assign slice_hold_o = (store_cnt >= sampler_pkg::COEFF_PER_CLK) | clear_i;
  assign take         = slice_valid_i & ~slice_hold_o;

  // candidate test, bounded values map to eta - (v mod 5) mod q
  always_comb begin
    logic [sampler_pkg::REJS_CAND_W-2:0] field;
    logic [sampler_pkg::REJB_CAND_W-1:0] nib;
    logic [2:0]                          rem;
    cand_val = '{default: '0};
    cand_ok  = '0;
    field    = '0;
    nib      = '0;
    rem      = '0;
    if (mode_i == sampler_pkg::MODE_REJ_BOUNDED) begin
      for (int i = 0; i < sampler_pkg::REJB_NUM_CAND; i++) begin
        nib        = slice_data_i[i*sampler_pkg::REJB_CAND_W +: sampler_pkg::REJB_CAND_W];
        rem        = 3'(nib % 5);
        cand_ok[i] = (nib < sampler_pkg::REJB_BOUND);
        cand_val[i] = (rem <= sampler_pkg::ETA) ?
                      sampler_pkg::COEFF_W'(sampler_pkg::ETA - rem) :
                      sampler_pkg::MLDSA_Q + sampler_pkg::COEFF_W'(sampler_pkg::ETA) -
                      sampler_pkg::COEFF_W'(rem);
      end
    end else begin
      for (int i = 0; i < sampler_pkg::REJS_NUM_CAND; i++) begin
        field       = slice_data_i[i*sampler_pkg::REJS_CAND_W +: sampler_pkg::REJS_CAND_W-1];
        cand_ok[i]  = ({1'b0, field} < sampler_pkg::MLDSA_Q);
        cand_val[i] = {1'b0, field};
      end
    end
  end

  // append accepted values behind the stored ones, lowest field first
  always_comb begin
    merged     = store_q;
    merged_cnt = {1'b0, store_cnt};
    for (int i = 0; i < sampler_pkg::REJB_NUM_CAND; i++) begin
      if (take && cand_ok[i]) begin
        if (merged_cnt < sampler_pkg::FILTER_DEPTH) begin
          merged[merged_cnt[sampler_pkg::FILTER_CNT_W-1:0]] = cand_val[i];
        end
        merged_cnt = merged_cnt + 1'b1;
      end
    end
  end

  assign beat_o = (merged_cnt >= sampler_pkg::COEFF_PER_CLK) & ~clear_i;

  always_comb begin
    for (int i = 0; i < sampler_pkg::COEFF_PER_CLK; i++) begin
      coeff_o[i] = merged[i];
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      store_cnt <= '0;
    end else if (clear_i) begin
      store_cnt <= '0;
    end else if (beat_o) begin
      store_cnt <= sampler_pkg::FILTER_CNT_W'(merged_cnt - sampler_pkg::COEFF_PER_CLK);
    end else begin
      store_cnt <= sampler_pkg::FILTER_CNT_W'(merged_cnt);
    end
  end

  // oldest four leave with the beat
  always_ff @(posedge clk) begin
    if (beat_o) begin
      for (int i = 0; i < sampler_pkg::FILTER_DEPTH - sampler_pkg::COEFF_PER_CLK; i++) begin
        store_q[i] <= merged[i + sampler_pkg::COEFF_PER_CLK];
      end
    end else begin
      store_q <= merged;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b)
    merged_cnt <= sampler_pkg::FILTER_DEPTH);

endmodule

// ==== design/block_piso.sv ====
/*
  squeeze block buffer
  takes one 192-bit block and hands it out in 96-bit or 32-bit slices, low bits first
*/
`timescale 1ns/1ps

module block_piso (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 clear_i,
  input  sampler_pkg::sampler_mode_e           mode_i,
  input  logic                                 block_valid_i,
  input  logic [sampler_pkg::BLOCK_W-1:0]      block_data_i,
  input  logic                                 slice_hold_i,
  output logic                                 block_hold_o,
  output logic                                 slice_valid_o,
  output logic [sampler_pkg::REJS_SLICE_W-1:0] slice_data_o
);

  logic [sampler_pkg::BLOCK_W-1:0]     block_q;
  logic [sampler_pkg::SLICE_CNT_W-1:0] slice_cnt;
  logic                                load;
  logic                                shift;

  // refuse new blocks while draining or being cleared
  assign block_hold_o  = (slice_cnt != '0) | clear_i;
  assign slice_valid_o = (slice_cnt != '0);
  assign slice_data_o  = block_q[sampler_pkg::REJS_SLICE_W-1:0];

  assign load  = block_valid_i & ~block_hold_o;
  assign shift = slice_valid_o & ~slice_hold_i;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      slice_cnt <= '0;
    end else if (clear_i) begin
      slice_cnt <= '0;
    end else if (load) begin
      slice_cnt <= (mode_i == sampler_pkg::MODE_REJ_BOUNDED) ?
                   sampler_pkg::SLICE_CNT_W'(sampler_pkg::REJB_SLICES) :
                   sampler_pkg::SLICE_CNT_W'(sampler_pkg::REJS_SLICES);
    end else if (shift) begin
      slice_cnt <= slice_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      block_q <= block_data_i;
    end else if (shift) begin
      block_q <= (mode_i == sampler_pkg::MODE_REJ_BOUNDED) ?
                 block_q >> sampler_pkg::REJB_SLICE_W :
                 block_q >> sampler_pkg::REJS_SLICE_W;
    end
  end

endmodule

// ==== design/coeff_counter.sv ====
/*
  coefficient beat counter
  flags the final beat and steps the destination address
*/
`timescale 1ns/1ps

module coeff_counter (
  input  logic                               clk,
  input  logic                               rst_b,
  input  logic                               zeroize_i,
  input  logic                               start_i,
  input  logic                               beat_i,
  input  logic [sampler_pkg::MEM_ADDR_W-1:0] dest_base_addr_i,
  output logic                               done_o,
  output logic [sampler_pkg::MEM_ADDR_W-1:0] addr_o
);

  logic [sampler_pkg::BEAT_CNT_W-1:0] beat_cnt;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      beat_cnt <= '0;
      addr_o   <= '0;
    end else if (zeroize_i) begin
      beat_cnt <= '0;
      addr_o   <= '0;
    end else if (start_i) begin
      beat_cnt <= '0;
      addr_o   <= dest_base_addr_i;
    end else if (beat_i) begin
      beat_cnt <= beat_cnt + 1'b1;
      addr_o   <= addr_o + 1'b1;
    end
  end

  assign done_o = (beat_cnt == sampler_pkg::BEAT_CNT_W'(sampler_pkg::BEAT_CNT));

endmodule

// ==== design/sampler_fsm.sv ====
/*
  sampler sequencer
  drives the hash process and run pulses and the busy flag
*/
`timescale 1ns/1ps

module sampler_fsm (
  input  logic clk,
  input  logic rst_b,
  input  logic zeroize_i,
  input  logic start_i,
  input  logic block_xfer_i,
  input  logic done_i,
  output logic process_o,
  output logic run_o,
  output logic busy_o
);

  sampler_pkg::sampler_state_e state, state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      sampler_pkg::ST_IDLE: begin
        if (start_i) begin
          state_nxt = sampler_pkg::ST_PROC;
        end
      end
      sampler_pkg::ST_PROC: begin
        state_nxt = sampler_pkg::ST_WAIT;
      end
      sampler_pkg::ST_WAIT: begin
        // done wins over a block arriving in the same cycle
        if (done_i) begin
          state_nxt = sampler_pkg::ST_DONE;
        end else if (block_xfer_i) begin
          state_nxt = sampler_pkg::ST_RUN;
        end
      end
      sampler_pkg::ST_RUN: begin
        state_nxt = done_i ? sampler_pkg::ST_DONE : sampler_pkg::ST_WAIT;
      end
      sampler_pkg::ST_DONE: begin
        state_nxt = sampler_pkg::ST_IDLE;
      end
      default: begin
        state_nxt = sampler_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= sampler_pkg::ST_IDLE;
    end else if (zeroize_i) begin
      state <= sampler_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign process_o = (state == sampler_pkg::ST_PROC);
  // no squeeze request once the last beat is counted
  assign run_o     = (state == sampler_pkg::ST_RUN) & ~done_i;
  assign busy_o    = start_i | (state != sampler_pkg::ST_IDLE);

  a_state_known: assert property (@(posedge clk) disable iff (!rst_b)
    !$isunknown(state));

endmodule

// ==== design/sampler_pkg.sv ====
/*
  sampler package
  widths, moduli, counts and encodings shared by the coefficient sampler
*/
package sampler_pkg;

  // squeeze block and piso slice rates
  localparam int unsigned BLOCK_W      = 192;
  localparam int unsigned REJS_SLICE_W = 96;
  localparam int unsigned REJB_SLICE_W = 32;
  localparam int unsigned REJS_SLICES  = BLOCK_W / REJS_SLICE_W;
  localparam int unsigned REJB_SLICES  = BLOCK_W / REJB_SLICE_W;
  localparam int unsigned SLICE_CNT_W  = $clog2(REJB_SLICES + 1);

  // candidate fields, top bit of the uniform field is masked
  localparam int unsigned REJS_CAND_W   = 24;
  localparam int unsigned REJB_CAND_W   = 4;
  localparam int unsigned REJS_NUM_CAND = REJS_SLICE_W / REJS_CAND_W;
  localparam int unsigned REJB_NUM_CAND = REJB_SLICE_W / REJB_CAND_W;

  localparam int unsigned COEFF_W       = 24;
  localparam int unsigned COEFF_PER_CLK = 4;
  localparam int unsigned COEFF_CNT     = 256;
  localparam int unsigned BEAT_CNT      = COEFF_CNT / COEFF_PER_CLK;
  localparam int unsigned BEAT_CNT_W    = $clog2(BEAT_CNT) + 1;

  localparam logic [COEFF_W-1:0] MLDSA_Q = 24'd8380417;
  localparam int unsigned REJB_BOUND     = 15;
  localparam int unsigned ETA            = 2;

  localparam int unsigned MEM_ADDR_W = 15;

  // three left below a beat plus one full bounded slice
  localparam int unsigned FILTER_DEPTH = 11;
  localparam int unsigned FILTER_CNT_W = $clog2(FILTER_DEPTH + 1);

  typedef enum logic {
    MODE_REJ_SAMPLE  = 1'b0,
    MODE_REJ_BOUNDED = 1'b1
  } sampler_mode_e;

  typedef enum logic [2:0] {ST_IDLE, ST_PROC, ST_WAIT, ST_RUN, ST_DONE} sampler_state_e;

endpackage
